// File: common/rv_settings.svh
`ifndef RV_SETTINGS_SVH
`define RV_SETTINGS_SVH

// Data path and address width
`define RV_XLEN 32

// Flow tag carried with each instruction
`define RV_TAG_WIDTH 3

// Instruction field widths
`define RV_REG_ADDR_WIDTH 5
`define RV_CSR_ADDR_WIDTH 12

// Return address offset for JAL/JALR
`define RV_LINK_OFFSET 4

`endif

// File: common/isa_pkg.sv
package isa_pkg;

    // Decoded operation handed over by the decode stage
    typedef enum logic [5:0] {
        NOP,
        LUI,
        ADD,
        SUB,
        SLT,
        SLTU,
        XOR,
        OR,
        AND,
        SLL,
        SRL,
        SRA,
        BEQ,
        BNE,
        BLT,
        BLTU,
        BGE,
        BGEU,
        JAL,
        JALR,
        LB,
        LBU,
        LH,
        LHU,
        LW,
        SB,
        SH,
        SW,
        CSRRW,
        CSRRS,
        CSRRC,
        CSRRWI,
        CSRRSI,
        CSRRCI,
        ECALL,
        EBREAK,
        MRET
    } op_e;

    // Field positions inside the instruction word
    localparam int RD_LSB  = 7;
    localparam int RD_MSB  = 11;
    localparam int RS1_LSB = 15;
    localparam int RS1_MSB = 19;
    localparam int CSR_LSB = 20;
    localparam int CSR_MSB = 31;

endpackage

// File: common/priv_pkg.sv
package priv_pkg;

    typedef enum logic [1:0] {
        PRIV_USER       = 2'b00,
        PRIV_SUPERVISOR = 2'b01,
        PRIV_MACHINE    = 2'b11
    } priv_level_e;

    // Cause codes as written to mcause, code 10 is reserved and marks no trap
    typedef enum logic [3:0] {
        EXC_INST_MISALIGNED = 4'd0,
        EXC_ILLEGAL_INST    = 4'd2,
        EXC_BREAKPOINT      = 4'd3,
        EXC_NONE            = 4'd10,
        EXC_ECALL_M         = 4'd11
    } exc_code_e;

    // Operation applied to the addressed CSR
    typedef enum logic [1:0] {
        CSR_NONE,
        CSR_WRITE,
        CSR_SET,
        CSR_CLEAR
    } csr_op_e;

endpackage

// File: execute/alu.sv
`timescale 1ns/1ns
`include "rv_settings.svh"

module alu (
    input  isa_pkg::op_e            operation_i,
    input  logic [`RV_XLEN-1:0]     pc_i,
    input  logic [`RV_XLEN-1:0]     first_operand_i,
    input  logic [`RV_XLEN-1:0]     second_operand_i,
    input  logic [`RV_XLEN-1:0]     third_operand_i,
    output logic [`RV_XLEN-1:0]     sum_o,
    output logic [`RV_XLEN-1:0]     sum2_o,
    output logic [`RV_XLEN-1:0]     and_o,
    output logic [`RV_XLEN-1:0]     or_o,
    output logic [`RV_XLEN-1:0]     xor_o,
    output logic [`RV_XLEN-1:0]     sll_o,
    output logic [`RV_XLEN-1:0]     srl_o,
    output logic [`RV_XLEN-1:0]     sra_o,
    output logic                    equal_o,
    output logic                    less_o,
    output logic                    less_unsigned_o
);

    localparam int SHAMT_WIDTH = $clog2(`RV_XLEN);

    logic [`RV_XLEN-1:0]     sum2_a;
    logic [`RV_XLEN-1:0]     sum2_b;
    logic [SHAMT_WIDTH-1:0]  shamt;

    assign shamt = second_operand_i[SHAMT_WIDTH-1:0];

    // Second adder serves the link value, SUB and the branch target
    always_comb begin
        unique case (operation_i)
            isa_pkg::JAL, isa_pkg::JALR: begin
                sum2_a = pc_i;
                sum2_b = `RV_XLEN'(`RV_LINK_OFFSET);
            end
            isa_pkg::SUB: begin
                sum2_a = first_operand_i;
                sum2_b = -second_operand_i;
            end
            default: begin
                sum2_a = pc_i;
                sum2_b = third_operand_i;
            end
        endcase
    end

    assign sum_o  = first_operand_i + second_operand_i;
    assign sum2_o = sum2_a + sum2_b;
    assign and_o  = first_operand_i & second_operand_i;
    assign or_o   = first_operand_i | second_operand_i;
    assign xor_o  = first_operand_i ^ second_operand_i;
    assign sll_o  = first_operand_i << shamt;
    assign srl_o  = first_operand_i >> shamt;
    assign sra_o  = $signed(first_operand_i) >>> shamt;

    // Compare flags shared by branches and SLT/SLTU
    assign equal_o         = first_operand_i == second_operand_i;
    assign less_o          = $signed(first_operand_i) < $signed(second_operand_i);
    assign less_unsigned_o = first_operand_i < second_operand_i;

endmodule

// File: execute/branch_unit.sv
`timescale 1ns/1ns
`include "rv_settings.svh"

module branch_unit (
    input  isa_pkg::op_e            operation_i,
    input  logic [`RV_XLEN-1:0]     sum_i,
    input  logic [`RV_XLEN-1:0]     sum2_i,
    input  logic                    equal_i,
    input  logic                    less_i,
    input  logic                    less_unsigned_i,
    input  logic                    killed_i,
    output logic                    jump_o,
    output logic [`RV_XLEN-1:0]     jump_target_o
);

    logic taken;

    always_comb begin
        unique case (operation_i)
            isa_pkg::BEQ:                taken = equal_i;
            isa_pkg::BNE:                taken = ~equal_i;
            isa_pkg::BLT:                taken = less_i;
            isa_pkg::BLTU:               taken = less_unsigned_i;
            isa_pkg::BGE:                taken = ~less_i;
            isa_pkg::BGEU:               taken = ~less_unsigned_i;
            isa_pkg::JAL, isa_pkg::JALR: taken = 1'b1;
            default:                     taken = 1'b0;
        endcase
    end

    assign jump_o = taken & ~killed_i;

    // JALR target is rs1 plus immediate with bit 0 dropped
    always_comb begin
        unique case (operation_i)
            isa_pkg::JALR: jump_target_o = {sum_i[`RV_XLEN-1:1], 1'b0};
            isa_pkg::JAL:  jump_target_o = sum_i;
            default:       jump_target_o = sum2_i;
        endcase
    end

endmodule

// File: execute/lsu_request.sv
`timescale 1ns/1ns
`include "rv_settings.svh"

module lsu_request (
    input  isa_pkg::op_e            operation_i,
    input  logic [`RV_XLEN-1:0]     sum_i,
    input  logic [`RV_XLEN-1:0]     third_operand_i,
    output logic [`RV_XLEN-1:0]     mem_address_o,
    output logic                    mem_read_enable_o,
    output logic [3:0]              mem_write_enable_o,
    output logic [`RV_XLEN-1:0]     mem_write_data_o
);

    // Word aligned, lanes select the bytes
    assign mem_address_o = {sum_i[`RV_XLEN-1:2], 2'b00};

    assign mem_read_enable_o = operation_i inside {isa_pkg::LB, isa_pkg::LBU, isa_pkg::LH,
                                                   isa_pkg::LHU, isa_pkg::LW};

    always_comb begin
        unique case (operation_i)
            isa_pkg::SB: begin
                unique case (sum_i[1:0])
                    2'b00:   mem_write_enable_o = 4'b0001;
                    2'b01:   mem_write_enable_o = 4'b0010;
                    2'b10:   mem_write_enable_o = 4'b0100;
                    default: mem_write_enable_o = 4'b1000;
                endcase
            end
            isa_pkg::SH: mem_write_enable_o = sum_i[1] ? 4'b1100 : 4'b0011;
            isa_pkg::SW: mem_write_enable_o = 4'b1111;
            default:     mem_write_enable_o = 4'b0000;
        endcase
    end

    // Narrow stores repeat their data on every lane
    always_comb begin
        unique case (operation_i)
            isa_pkg::SB: mem_write_data_o = {4{third_operand_i[7:0]}};
            isa_pkg::SH: mem_write_data_o = {2{third_operand_i[15:0]}};
            default:     mem_write_data_o = third_operand_i;
        endcase
    end

endmodule

// File: execute/csr_access.sv
`timescale 1ns/1ns
`include "rv_settings.svh"

module csr_access (
    input  isa_pkg::op_e                   operation_i,
    input  logic [`RV_XLEN-1:0]            instruction_i,
    input  logic [`RV_XLEN-1:0]            first_operand_i,
    input  priv_pkg::priv_level_e          privilege_i,
    output logic [`RV_CSR_ADDR_WIDTH-1:0]  csr_address_o,
    output logic                           csr_read_enable_o,
    output logic                           csr_write_enable_o,
    output priv_pkg::csr_op_e              csr_operation_o,
    output logic [`RV_XLEN-1:0]            csr_data_o,
    output logic                           illegal_csr_o
);

    logic [`RV_REG_ADDR_WIDTH-1:0]  rd;
    logic [`RV_REG_ADDR_WIDTH-1:0]  rs1;
    logic                           read_request;
    logic                           write_request;
    logic                           read_only;
    logic                           over_privileged;

    assign rd            = instruction_i[isa_pkg::RD_MSB:isa_pkg::RD_LSB];
    assign rs1           = instruction_i[isa_pkg::RS1_MSB:isa_pkg::RS1_LSB];
    assign csr_address_o = instruction_i[isa_pkg::CSR_MSB:isa_pkg::CSR_LSB];

    // rd == x0 skips the read, rs1 == x0 skips the write
    always_comb begin
        unique case (operation_i)
            isa_pkg::CSRRW, isa_pkg::CSRRWI: begin
                read_request  = rd != '0;
                write_request = 1'b1;
            end
            isa_pkg::CSRRS, isa_pkg::CSRRC, isa_pkg::CSRRSI, isa_pkg::CSRRCI: begin
                read_request  = 1'b1;
                write_request = rs1 != '0;
            end
            default: begin
                read_request  = 1'b0;
                write_request = 1'b0;
            end
        endcase
    end

    // Top two address bits set means read only, next two hold the privilege
    assign read_only       = &csr_address_o[`RV_CSR_ADDR_WIDTH-1 -: 2];
    assign over_privileged = csr_address_o[`RV_CSR_ADDR_WIDTH-3 -: 2] > privilege_i;

    assign illegal_csr_o = (read_only & write_request) |
                           (over_privileged & (read_request | write_request));

    assign csr_read_enable_o  = read_request & ~illegal_csr_o;
    assign csr_write_enable_o = write_request & ~illegal_csr_o;

    always_comb begin
        unique case (operation_i)
            isa_pkg::CSRRW, isa_pkg::CSRRWI: csr_operation_o = priv_pkg::CSR_WRITE;
            isa_pkg::CSRRS, isa_pkg::CSRRSI: csr_operation_o = priv_pkg::CSR_SET;
            isa_pkg::CSRRC, isa_pkg::CSRRCI: csr_operation_o = priv_pkg::CSR_CLEAR;
            default:                         csr_operation_o = priv_pkg::CSR_NONE;
        endcase
    end

    // Immediate forms carry a 5 bit unsigned value in the rs1 field
    assign csr_data_o = operation_i inside {isa_pkg::CSRRW, isa_pkg::CSRRS, isa_pkg::CSRRC}
                        ? first_operand_i
                        : {{(`RV_XLEN-`RV_REG_ADDR_WIDTH){1'b0}}, rs1};

endmodule

// File: execute/trap_control.sv
`timescale 1ns/1ns
`include "rv_settings.svh"

module trap_control (
    input  logic                        clk,
    input  logic                        reset,
    input  isa_pkg::op_e                operation_i,
    input  logic [`RV_TAG_WIDTH-1:0]    tag_i,
    input  logic                        exc_illegal_inst_i,
    input  logic                        illegal_csr_i,
    input  logic                        exc_misaligned_fetch_i,
    input  logic                        interrupt_pending_i,
    input  logic                        jump_i,
    output logic                        killed_o,
    output logic                        raise_exception_o,
    output priv_pkg::exc_code_e         exception_code_o,
    output logic                        machine_return_o,
    output logic                        interrupt_ack_o
);

    logic [`RV_TAG_WIDTH-1:0] tag;

    //////////////////////////////////////////////////
    // Flow tag

    // Nothing is live while reset is high
    assign killed_o = reset | (tag != tag_i);

    // Any change of flow opens a new tag
    always_ff @(posedge clk) begin
        if (reset) begin
            tag <= '0;
        end else if (jump_i | raise_exception_o | machine_return_o | interrupt_ack_o) begin
            tag <= tag + 1'b1;
        end
    end

    //////////////////////////////////////////////////
    // Trap priority

    always_comb begin
        raise_exception_o = 1'b0;
        exception_code_o  = priv_pkg::EXC_NONE;
        machine_return_o  = 1'b0;
        interrupt_ack_o   = 1'b0;
        if (!killed_o) begin
            if (exc_illegal_inst_i | illegal_csr_i) begin
                raise_exception_o = 1'b1;
                exception_code_o  = priv_pkg::EXC_ILLEGAL_INST;
            end else if (exc_misaligned_fetch_i) begin
                raise_exception_o = 1'b1;
                exception_code_o  = priv_pkg::EXC_INST_MISALIGNED;
            end else if (operation_i == isa_pkg::ECALL) begin
                raise_exception_o = 1'b1;
                exception_code_o  = priv_pkg::EXC_ECALL_M;
            end else if (operation_i == isa_pkg::EBREAK) begin
                raise_exception_o = 1'b1;
                exception_code_o  = priv_pkg::EXC_BREAKPOINT;
            end else if (operation_i == isa_pkg::MRET) begin
                machine_return_o = 1'b1;
            end else if (interrupt_pending_i) begin
                interrupt_ack_o = 1'b1;
            end
        end
    end

endmodule

// File: execute/writeback_stage.sv
`timescale 1ns/1ns
`include "rv_settings.svh"

module writeback_stage (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    stall_i,
    input  isa_pkg::op_e            operation_i,
    input  logic                    killed_i,
    input  logic [`RV_XLEN-1:0]     csr_data_read_i,
    input  logic [`RV_XLEN-1:0]     second_operand_i,
    input  logic [`RV_XLEN-1:0]     sum_i,
    input  logic [`RV_XLEN-1:0]     sum2_i,
    input  logic [`RV_XLEN-1:0]     and_i,
    input  logic [`RV_XLEN-1:0]     or_i,
    input  logic [`RV_XLEN-1:0]     xor_i,
    input  logic [`RV_XLEN-1:0]     sll_i,
    input  logic [`RV_XLEN-1:0]     srl_i,
    input  logic [`RV_XLEN-1:0]     sra_i,
    input  logic                    less_i,
    input  logic                    less_unsigned_i,
    output logic                    write_enable_o,
    output isa_pkg::op_e            operation_o,
    output logic [`RV_XLEN-1:0]     result_o
);

    logic [`RV_XLEN-1:0]  result;
    logic                 write_enable;

    //////////////////////////////////////////////////
    // Result select

    always_comb begin
        unique case (operation_i)
            isa_pkg::CSRRW, isa_pkg::CSRRS, isa_pkg::CSRRC,
            isa_pkg::CSRRWI, isa_pkg::CSRRSI, isa_pkg::CSRRCI: result = csr_data_read_i;
            isa_pkg::JAL, isa_pkg::JALR, isa_pkg::SUB:         result = sum2_i;
            isa_pkg::SLT:  result = {{(`RV_XLEN-1){1'b0}}, less_i};
            isa_pkg::SLTU: result = {{(`RV_XLEN-1){1'b0}}, less_unsigned_i};
            isa_pkg::AND:  result = and_i;
            isa_pkg::OR:   result = or_i;
            isa_pkg::XOR:  result = xor_i;
            isa_pkg::SLL:  result = sll_i;
            isa_pkg::SRL:  result = srl_i;
            isa_pkg::SRA:  result = sra_i;
            isa_pkg::LUI:  result = second_operand_i;
            default:       result = sum_i;
        endcase
    end

    // Stores and branches leave the register file alone
    assign write_enable = operation_i inside {isa_pkg::SB, isa_pkg::SH, isa_pkg::SW,
                                              isa_pkg::BEQ, isa_pkg::BNE, isa_pkg::BLT,
                                              isa_pkg::BLTU, isa_pkg::BGE, isa_pkg::BGEU}
                          ? 1'b0 : ~killed_i;

    //////////////////////////////////////////////////
    // Output registers, held while stalled

    always_ff @(posedge clk) begin
        if (reset) begin
            write_enable_o <= 1'b0;
        end else if (!stall_i) begin
            write_enable_o <= write_enable;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_i) begin
            operation_o <= operation_i;
            result_o    <= result;
        end
    end

endmodule

// File: execute/execute_top.sv
`timescale 1ns/1ns
`include "rv_settings.svh"

module execute_top (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           stall_i,
    input  logic [`RV_XLEN-1:0]            instruction_i,
    input  logic [`RV_XLEN-1:0]            pc_i,
    input  logic [`RV_XLEN-1:0]            first_operand_i,
    input  logic [`RV_XLEN-1:0]            second_operand_i,
    input  logic [`RV_XLEN-1:0]            third_operand_i,
    input  isa_pkg::op_e                   operation_i,
    input  logic [`RV_TAG_WIDTH-1:0]       tag_i,
    input  priv_pkg::priv_level_e          privilege_i,
    input  logic                           exc_illegal_inst_i,
    input  logic                           exc_misaligned_fetch_i,
    input  logic                           interrupt_pending_i,
    input  logic [`RV_XLEN-1:0]            csr_data_read_i,
    output logic                           killed_o,
    output logic                           write_enable_o,
    output isa_pkg::op_e                   operation_o,
    output logic [`RV_XLEN-1:0]            result_o,
    output logic [`RV_XLEN-1:0]            mem_address_o,
    output logic                           mem_read_enable_o,
    output logic [3:0]                     mem_write_enable_o,
    output logic [`RV_XLEN-1:0]            mem_write_data_o,
    output logic [`RV_CSR_ADDR_WIDTH-1:0]  csr_address_o,
    output logic                           csr_read_enable_o,
    output logic                           csr_write_enable_o,
    output priv_pkg::csr_op_e              csr_operation_o,
    output logic [`RV_XLEN-1:0]            csr_data_o,
    output logic                           jump_o,
    output logic [`RV_XLEN-1:0]            jump_target_o,
    output logic                           interrupt_ack_o,
    output logic                           machine_return_o,
    output logic                           raise_exception_o,
    output priv_pkg::exc_code_e            exception_code_o
);

    logic [`RV_XLEN-1:0]  sum;
    logic [`RV_XLEN-1:0]  sum2;
    logic [`RV_XLEN-1:0]  and_result;
    logic [`RV_XLEN-1:0]  or_result;
    logic [`RV_XLEN-1:0]  xor_result;
    logic [`RV_XLEN-1:0]  sll_result;
    logic [`RV_XLEN-1:0]  srl_result;
    logic [`RV_XLEN-1:0]  sra_result;
    logic                 equal;
    logic                 less;
    logic                 less_unsigned;
    logic                 illegal_csr;

    //////////////////////////////////////////////////
    // Datapath

    alu alu0 (
        .operation_i      (operation_i),
        .pc_i             (pc_i),
        .first_operand_i  (first_operand_i),
        .second_operand_i (second_operand_i),
        .third_operand_i  (third_operand_i),
        .sum_o            (sum),
        .sum2_o           (sum2),
        .and_o            (and_result),
        .or_o             (or_result),
        .xor_o            (xor_result),
        .sll_o            (sll_result),
        .srl_o            (srl_result),
        .sra_o            (sra_result),
        .equal_o          (equal),
        .less_o           (less),
        .less_unsigned_o  (less_unsigned)
    );

    branch_unit branch0 (
        .operation_i     (operation_i),
        .sum_i           (sum),
        .sum2_i          (sum2),
        .equal_i         (equal),
        .less_i          (less),
        .less_unsigned_i (less_unsigned),
        .killed_i        (killed_o),
        .jump_o          (jump_o),
        .jump_target_o   (jump_target_o)
    );

    lsu_request lsu0 (
        .operation_i        (operation_i),
        .sum_i              (sum),
        .third_operand_i    (third_operand_i),
        .mem_address_o      (mem_address_o),
        .mem_read_enable_o  (mem_read_enable_o),
        .mem_write_enable_o (mem_write_enable_o),
        .mem_write_data_o   (mem_write_data_o)
    );

    csr_access csr0 (
        .operation_i        (operation_i),
        .instruction_i      (instruction_i),
        .first_operand_i    (first_operand_i),
        .privilege_i        (privilege_i),
        .csr_address_o      (csr_address_o),
        .csr_read_enable_o  (csr_read_enable_o),
        .csr_write_enable_o (csr_write_enable_o),
        .csr_operation_o    (csr_operation_o),
        .csr_data_o         (csr_data_o),
        .illegal_csr_o      (illegal_csr)
    );

    //////////////////////////////////////////////////
    // Control and writeback

    trap_control trap0 (
        .clk                    (clk),
        .reset                  (reset),
        .operation_i            (operation_i),
        .tag_i                  (tag_i),
        .exc_illegal_inst_i     (exc_illegal_inst_i),
        .illegal_csr_i          (illegal_csr),
        .exc_misaligned_fetch_i (exc_misaligned_fetch_i),
        .interrupt_pending_i    (interrupt_pending_i),
        .jump_i                 (jump_o),
        .killed_o               (killed_o),
        .raise_exception_o      (raise_exception_o),
        .exception_code_o       (exception_code_o),
        .machine_return_o       (machine_return_o),
        .interrupt_ack_o        (interrupt_ack_o)
    );

    writeback_stage wb0 (
        .clk              (clk),
        .reset            (reset),
        .stall_i          (stall_i),
        .operation_i      (operation_i),
        .killed_i         (killed_o),
        .csr_data_read_i  (csr_data_read_i),
        .second_operand_i (second_operand_i),
        .sum_i            (sum),
        .sum2_i           (sum2),
        .and_i            (and_result),
        .or_i             (or_result),
        .xor_i            (xor_result),
        .sll_i            (sll_result),
        .srl_i            (srl_result),
        .sra_i            (sra_result),
        .less_i           (less),
        .less_unsigned_i  (less_unsigned),
        .write_enable_o   (write_enable_o),
        .operation_o      (operation_o),
        .result_o         (result_o)
    );

endmodule

// File: verification/execute_tb.sv
`timescale 1ns/1ns
`include "rv_settings.svh"

module execute_tb;

    localparam int VEC_COUNT    = 23;
    localparam int FIELDS       = 11;
    localparam int RESET_CYCLES = 8;
    localparam int CYCLE_LIMIT  = RESET_CYCLES + 3 * VEC_COUNT + 20;

    logic                           clk;
    logic                           reset;
    logic                           stall;
    logic [`RV_XLEN-1:0]            instruction;
    logic [`RV_XLEN-1:0]            pc;
    logic [`RV_XLEN-1:0]            first_operand;
    logic [`RV_XLEN-1:0]            second_operand;
    logic [`RV_XLEN-1:0]            third_operand;
    isa_pkg::op_e                   operation;
    logic [`RV_TAG_WIDTH-1:0]       tag;
    priv_pkg::priv_level_e          privilege;
    logic                           exc_illegal_inst;
    logic                           exc_misaligned_fetch;
    logic                           interrupt_pending;
    logic [`RV_XLEN-1:0]            csr_data_read;

    logic                           killed;
    logic                           write_enable;
    isa_pkg::op_e                   operation_out;
    logic [`RV_XLEN-1:0]            result;
    logic [`RV_XLEN-1:0]            mem_address;
    logic                           mem_read_enable;
    logic [3:0]                     mem_write_enable;
    logic [`RV_XLEN-1:0]            mem_write_data;
    logic [`RV_CSR_ADDR_WIDTH-1:0]  csr_address;
    logic                           csr_read_enable;
    logic                           csr_write_enable;
    priv_pkg::csr_op_e              csr_operation;
    logic [`RV_XLEN-1:0]            csr_data;
    logic                           jump;
    logic [`RV_XLEN-1:0]            jump_target;
    logic                           interrupt_ack;
    logic                           machine_return;
    logic                           raise_exception;
    priv_pkg::exc_code_e            exception_code;

    // Eleven words per vector as listed in the golden file header
    logic [31:0]   golden [0:VEC_COUNT*FIELDS-1];
    isa_pkg::op_e  held_op;
    int            errors = 0;
    int            cycles = 0;

    execute_top dut0 (
        .clk(clk), .reset(reset), .stall_i(stall), .instruction_i(instruction), .pc_i(pc),
        .first_operand_i(first_operand), .second_operand_i(second_operand),
        .third_operand_i(third_operand), .operation_i(operation), .tag_i(tag),
        .privilege_i(privilege), .exc_illegal_inst_i(exc_illegal_inst),
        .exc_misaligned_fetch_i(exc_misaligned_fetch),
        .interrupt_pending_i(interrupt_pending), .csr_data_read_i(csr_data_read),
        .killed_o(killed), .write_enable_o(write_enable), .operation_o(operation_out),
        .result_o(result), .mem_address_o(mem_address), .mem_read_enable_o(mem_read_enable),
        .mem_write_enable_o(mem_write_enable), .mem_write_data_o(mem_write_data),
        .csr_address_o(csr_address), .csr_read_enable_o(csr_read_enable),
        .csr_write_enable_o(csr_write_enable), .csr_operation_o(csr_operation),
        .csr_data_o(csr_data), .jump_o(jump), .jump_target_o(jump_target),
        .interrupt_ack_o(interrupt_ack), .machine_return_o(machine_return),
        .raise_exception_o(raise_exception), .exception_code_o(exception_code)
    );

    //////////////////////////////////////////////////
    // Clock and run limit

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("run stopped after %0d cycles without reaching the end", CYCLE_LIMIT);
        $display("%0d errors", errors);
        $display("tests failed");
        $finish;
    end

    //////////////////////////////////////////////////
    // Helpers

    task automatic compare_field(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        if (actual !== expected) begin
            errors++;
            $display("mismatch at %0t: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    task automatic apply_vector(input int idx);
        logic [31:0] ctrl;
        int          base;
        base = idx * FIELDS;
        ctrl = golden[base];
        stall                = ctrl[24];
        operation            = isa_pkg::op_e'(ctrl[21:16]);
        tag                  = ctrl[14:12];
        privilege            = priv_pkg::priv_level_e'(ctrl[9:8]);
        exc_illegal_inst     = ctrl[6];
        exc_misaligned_fetch = ctrl[5];
        interrupt_pending    = ctrl[4];
        instruction          = golden[base + 1];
        pc                   = golden[base + 2];
        first_operand        = golden[base + 3];
        second_operand       = golden[base + 4];
        third_operand        = golden[base + 5];
        csr_data_read        = golden[base + 6];
        // Output register follows the operation only when not stalled
        if (!ctrl[24]) begin
            held_op = isa_pkg::op_e'(ctrl[21:16]);
        end
    endtask

    task automatic check_combinational(input int idx);
        logic [31:0] flags;
        logic [3:0]  kind;
        int          base;
        base  = idx * FIELDS;
        flags = golden[base + 7];
        kind  = golden[base][31:28];
        compare_field("killed_o", 32'(flags[28]), 32'(killed));
        compare_field("mem_read_enable_o", 32'(flags[20]), 32'(mem_read_enable));
        compare_field("mem_write_enable_o", 32'(flags[19:16]), 32'(mem_write_enable));
        compare_field("csr_read_enable_o", 32'(flags[15]), 32'(csr_read_enable));
        compare_field("csr_write_enable_o", 32'(flags[14]), 32'(csr_write_enable));
        compare_field("csr_operation_o", 32'(flags[13:12]), 32'(csr_operation));
        compare_field("jump_o", 32'(flags[11]), 32'(jump));
        compare_field("raise_exception_o", 32'(flags[10]), 32'(raise_exception));
        compare_field("machine_return_o", 32'(flags[9]), 32'(machine_return));
        compare_field("interrupt_ack_o", 32'(flags[8]), 32'(interrupt_ack));
        compare_field("exception_code_o", 32'(flags[7:4]), 32'(exception_code));
        // Kind picks which data outputs the two expected words stand for
        if (kind == 4'd1) begin
            compare_field("jump_target_o", golden[base + 8], jump_target);
        end
        if (kind == 4'd2) begin
            compare_field("mem_address_o", golden[base + 8], mem_address);
            compare_field("mem_write_data_o", golden[base + 9], mem_write_data);
        end
        if (kind == 4'd3) begin
            compare_field("csr_address_o", golden[base + 8], 32'(csr_address));
            compare_field("csr_data_o", golden[base + 9], csr_data);
        end
    endtask

    task automatic check_registered(input int idx);
        logic [31:0] flags;
        int          base;
        base  = idx * FIELDS;
        flags = golden[base + 7];
        compare_field("write_enable_o", 32'(flags[24]), 32'(write_enable));
        compare_field("flow tag", 32'(flags[3:0]), 32'(dut0.trap0.tag));
        if (flags[24]) begin
            compare_field("result_o", golden[base + 10], result);
            compare_field("operation_o", 32'(held_op), 32'(operation_out));
        end
    endtask

    //////////////////////////////////////////////////
    // Main sequence

    initial begin
        reset                = 1'b1;
        stall                = 1'b0;
        instruction          = '0;
        pc                   = '0;
        first_operand        = '0;
        second_operand       = '0;
        third_operand        = '0;
        operation            = isa_pkg::NOP;
        tag                  = '0;
        privilege            = priv_pkg::PRIV_MACHINE;
        exc_illegal_inst     = 1'b0;
        exc_misaligned_fetch = 1'b0;
        interrupt_pending    = 1'b0;
        csr_data_read        = '0;
        held_op              = isa_pkg::NOP;
        $readmemh("verification/execute_golden.txt", golden);
        if ($isunknown(golden[VEC_COUNT*FIELDS-1])) begin
            errors++;
            $display("golden file holds fewer vectors than expected");
        end

        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        for (int vec = 0; vec < VEC_COUNT; vec++) begin
            @(negedge clk);
            apply_vector(vec);
            #40;
            check_combinational(vec);
            @(posedge clk);
            #1;
            check_registered(vec);
        end

        $display("%0d errors in %0d vectors", errors, VEC_COUNT);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// File: verification/execute_golden.txt
// ctrl instr pc op1 op2 op3 csr_rd flags exp_a exp_b result
// ctrl: kind stall op(2) tag priv exc(ill,mis,irq) 0
// flags: killed we mem_re mem_we csr(re,we,op) trap(jmp,exc,mret,ack) code tag_after
00020300 0 100 5 7 0 0 010000a0 0 0 c
00030300 0 104 3 5 0 0 010000a0 0 0 fffffffe
000b0300 0 108 f0000000 4 0 0 010000a0 0 0 ff000000
00040300 0 10c ffffffff 1 0 0 010000a0 0 0 1
00010300 0 110 0 12345000 0 0 010000a0 0 0 12345000
01020300 0 114 1 1 0 0 010000a0 0 0 12345000
100e0300 0 1000 fffffff0 3 20 0 000008a1 1020 0 0
00120350 0 1004 1 2 0 0 100000a1 0 0 0
10111300 0 2000 1 ffffffff 40 0 000000a1 2040 0 0
10131300 0 500 3001 4 0 0 010008a2 3004 0 504
201a2300 0 600 1000 6 abcd 0 000c00a2 1004 abcdabcd 0
20192300 0 604 2000 1 12345678 0 000200a2 2000 78787878 0
20182300 0 608 3000 8 0 0 011000a2 3008 0 3008
301d2300 30028080 60c 8 0 0 1800 0100e0a2 300 8 1800
301f2300 340f8000 610 0 0 0 55 010050a2 340 1f 55
301c2300 f1400080 614 9 0 0 77 01001423 f14 9 77
301d3000 30000080 618 0 0 0 0 01002424 300 0 0
00224330 0 61c 0 0 0 0 01000405 0 0 0
00225310 0 620 0 0 0 0 010004b6 0 0 0
00236310 0 624 0 0 0 0 01000437 0 0 0
00247310 0 628 0 0 0 0 010002a0 0 0 0
00000310 0 62c 0 0 0 0 010001a1 0 0 0
00021370 0 630 2 3 0 0 01000422 0 0 5

// File: sources.f
+incdir+common
common/isa_pkg.sv
common/priv_pkg.sv
execute/alu.sv
execute/branch_unit.sv
execute/lsu_request.sv
execute/csr_access.sv
execute/trap_control.sv
execute/writeback_stage.sv
execute/execute_top.sv
verification/execute_tb.sv

// File: run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --top-module execute_tb -f sources.f

output=$(./obj_dir/Vexecute_tb)
echo "$output"

# Exit status follows the search for the pass line
echo "$output" | grep -qx "all tests passed"
